// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wall
TOP       = tb_cart_loader
FILELIST  = all.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
verilog/cart_pkg.sv
verilog/load_bus_if.sv
verilog/rom_header_detect.sv
verilog/cheat_code_assembler.sv
verilog/ram_clear_sequencer.sv
verilog/backup_ram_sync.sv
verilog/cart_loader_top.sv
bench/tb_clock_gen.sv
bench/tb_cart_loader.sv

// File: bench/tb_cart_loader.sv
/* Testbench for the cartridge loader. Checks live in concurrent assertions;
   the sector ack model uses random delays from a fixed seed. */
`default_nettype none

module tb_cart_loader;
	import cart_pkg::*;

	localparam int CYCLE_LIMIT = 400000;

	logic clk_sys, RESET, ioctl_download, ioctl_wr;
	logic [7:0] ioctl_index;
	load_addr_t ioctl_addr;
	load_word_t ioctl_dout;
	header_sel_t header_sel;
	logic [1:0] region_sel;
	wram_pattern_t wram_pattern;
	logic img_mounted, img_readonly, bk_load_req, bk_save_req, sd_ack;
	logic [63:0] img_size;
	rom_type_t rom_type;
	mem_mask_t rom_mask, ram_mask;
	logic pal, gg_code_valid, fill_wr, sd_rd, sd_wr, bk_busy, bk_loading, core_reset;
	cheat_code_t gg_code;
	fill_addr_t fill_addr;
	fill_data_t fill_data;
	lba_t sd_lba;

	// Expected values and bench bookkeeping
	logic hdr_check, exp_pal, exp_loading;
	rom_type_t exp_rom_type;
	mem_mask_t exp_rom_mask, exp_ram_mask;
	logic [127:0] exp_code;
	logic req_seen;
	int fill_count, req_count, valid_pulses, cycles;
	integer seed;

	tb_clock_gen clkgen (.clk_sys(clk_sys));

	cart_loader_top dut0 (.*);

	task automatic report_value(string name, logic [128:0] got, logic [128:0] exp);
		$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic fill_data_t expected_fill(fill_addr_t a, wram_pattern_t p);
		case (p)
			PAT_9966: return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			PAT_00FF: return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			PAT_55:   return 8'h55;
			default:  return 8'hFF;
		endcase
	endfunction

	// ======================================================================
	// Assertions
	// ======================================================================
	a_hdr_type: assert property (@(posedge clk_sys) disable iff (RESET)
			hdr_check |-> rom_type == exp_rom_type)
		else report_value("rom_type", 129'(rom_type), 129'(exp_rom_type));
	a_hdr_rom: assert property (@(posedge clk_sys) disable iff (RESET)
			hdr_check |-> rom_mask == exp_rom_mask)
		else report_value("rom_mask", 129'(rom_mask), 129'(exp_rom_mask));
	a_hdr_ram: assert property (@(posedge clk_sys) disable iff (RESET)
			hdr_check |-> ram_mask == exp_ram_mask)
		else report_value("ram_mask", 129'(ram_mask), 129'(exp_ram_mask));
	a_pal: assert property (@(posedge clk_sys) disable iff (RESET)
			hdr_check |-> pal == exp_pal)
		else report_value("pal", 129'(pal), 129'(exp_pal));
	a_code: assert property (@(posedge clk_sys) disable iff (RESET)
			gg_code_valid |-> gg_code == {1'b1, exp_code})
		else report_value("gg_code", gg_code, {1'b1, exp_code});
	a_code_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
			gg_code_valid |=> !gg_code_valid)
		else report_value("gg_code_valid", 129'(gg_code_valid), 129'(1'b0));
	a_code_time: assert property (@(posedge clk_sys) disable iff (RESET)
			(ioctl_download && ioctl_index == 8'hFF && ioctl_wr
			&& ioctl_addr[3:0] == 4'd14) |=> gg_code_valid)
		else report_value("gg_code_valid", 129'(gg_code_valid), 129'(1'b1));
	a_fill_data: assert property (@(posedge clk_sys) disable iff (RESET)
			fill_wr |-> fill_data == expected_fill(fill_addr, wram_pattern))
		else report_value("fill_data", 129'(fill_data),
			129'(expected_fill(fill_addr, wram_pattern)));
	a_fill_step: assert property (@(posedge clk_sys) disable iff (RESET)
			(fill_wr && !(&fill_addr)) |=>
			fill_wr && fill_addr == $past(fill_addr) + fill_addr_t'(1))
		else report_value("fill_addr", 129'(fill_addr),
			129'($past(fill_addr) + fill_addr_t'(1)));
	a_fill_count: assert property (@(posedge clk_sys) disable iff (RESET)
			$fell(fill_wr) |-> fill_count == 2 ** FILL_ADDR_BITS)
		else report_value("fill_count", 129'(fill_count), 129'(2 ** FILL_ADDR_BITS));
	a_clear_reset: assert property (@(posedge clk_sys) disable iff (RESET)
			fill_wr |-> core_reset)
		else report_value("core_reset", 129'(core_reset), 129'(1'b1));
	a_lba: assert property (@(posedge clk_sys) disable iff (RESET)
			($rose(sd_rd) || $rose(sd_wr)) |-> sd_lba == req_count)
		else report_value("sd_lba", 129'(sd_lba), 129'(req_count));
	a_run_kind: assert property (@(posedge clk_sys) disable iff (RESET)
			bk_busy |-> bk_loading == exp_loading)
		else report_value("bk_loading", 129'(bk_loading), 129'(exp_loading));
	a_rd_only: assert property (@(posedge clk_sys) disable iff (RESET)
			sd_rd |-> exp_loading && !sd_wr)
		else report_value("sd_rd", 129'(sd_rd), 129'(exp_loading));
	a_wr_only: assert property (@(posedge clk_sys) disable iff (RESET)
			sd_wr |-> !exp_loading && !sd_rd)
		else report_value("sd_wr", 129'(sd_wr), 129'(!exp_loading));
	a_req_drop: assert property (@(posedge clk_sys) disable iff (RESET)
			$rose(sd_ack) |=> !sd_rd && !sd_wr)
		else report_value("sd_rd|sd_wr", 129'(sd_rd | sd_wr), 129'(1'b0));
	a_sectors: assert property (@(posedge clk_sys) disable iff (RESET)
			$fell(bk_busy) |-> req_count == 16)
		else report_value("sector count", 129'(req_count), 129'(16));

	always @(posedge clk_sys) begin
		fill_count <= fill_wr ? fill_count + 1 : 0;
		req_seen <= sd_rd | sd_wr;
		if (!bk_busy)
			req_count <= 0;
		else if ((sd_rd || sd_wr) && !req_seen)
			req_count <= req_count + 1;
		if (gg_code_valid)
			valid_pulses <= valid_pulses + 1;
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	// Sector ack model
	initial begin
		int d;
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd || sd_wr) begin
				d = 3 + ({$random(seed)} % 8);
				repeat (d - 1) @(posedge clk_sys);
				#1 sd_ack = 1'b1;
				d = 2 + ({$random(seed)} % 4);
				repeat (d) @(posedge clk_sys);
				#1 sd_ack = 1'b0;
			end
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic step(int n = 1);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic write_word(load_addr_t a, load_word_t d);
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr = 1'b1;
		step();
		ioctl_wr = 1'b0;
		step();
	endtask

	task automatic wait_idle();
		while (fill_wr || bk_busy || ioctl_download)
			step();
	endtask

	initial begin
		seed = 32'hca73_1e0b;
		cycles = 0;
		fill_count = 0;
		req_count = 0;
		req_seen = 1'b0;
		valid_pulses = 0;
		{RESET, ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout} = '0;
		ioctl_index = 8'h00;
		header_sel = HDR_LOROM;
		region_sel = 2'd0;
		wram_pattern = PAT_9966;
		{img_mounted, img_readonly, bk_load_req, bk_save_req} = 4'b1000;
		img_size = 64'd8192;
		{hdr_check, exp_pal, exp_loading} = 3'b001;
		exp_rom_type = '0;
		exp_rom_mask = '0;
		exp_ram_mask = '0;
		exp_code = '0;
		RESET = 1'b1;
		step(8);
		RESET = 1'b0;
		step(2);

		// LoROM image, save image read back at the end of the load
		ioctl_download = 1'b1;
		write_word(25'h0, 16'h0000);
		write_word(25'h2, 16'h0100);
		write_word(25'h81D6, 16'h0A00);
		write_word(25'h81D8, 16'h0003);
		step(3);
		ioctl_download = 1'b0;
		step();
		wait_idle();
		step(2);
		exp_rom_type = 8'd0;
		exp_rom_mask = 24'hFFFFF;
		exp_ram_mask = 24'h1FFF;
		exp_pal = 1'b1;
		hdr_check = 1'b1;
		step(4);

		// Save run
		exp_loading = 1'b0;
		bk_save_req = 1'b1;
		step();
		bk_save_req = 1'b0;
		while (!bk_busy)
			step();
		wait_idle();

		// Region forced by the menu
		hdr_check = 1'b0;
		region_sel = 2'd1;
		step(2);
		exp_pal = 1'b0;
		hdr_check = 1'b1;
		step(2);

		// Code file
		exp_code = {32'h8001_0042, 32'h00_7E12_34, 32'h0000_00AA, 32'h0000_0055};
		ioctl_index = 8'hFF;
		ioctl_download = 1'b1;
		for (int i = 0; i < 8; i++)
			write_word(load_addr_t'(2 * i), exp_code[16 * ((i & 6) == 0 ? 6 + i :
				(i < 4 ? i + 2 : (i < 6 ? i - 2 : i - 6))) +: 16]);
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		step(2);

		// Second load, auto header, another fill pattern
		hdr_check = 1'b0;
		header_sel = HDR_AUTO;
		wram_pattern = PAT_00FF;
		img_mounted = 1'b0;
		ioctl_download = 1'b1;
		write_word(25'h0, 16'h012B);
		step(2);
		ioctl_download = 1'b0;
		step();
		wait_idle();
		step(2);
		exp_rom_type = 8'd1;
		exp_rom_mask = 24'h1FFFFF;
		exp_ram_mask = 24'hFFF;
		hdr_check = 1'b1;
		step(4);

		if (valid_pulses != 1) begin
			$display("Cheat strobe seen %0d times instead of once", valid_pulses);
			$display("CHECKS FAILED");
			$fatal(1);
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
/* Free-running clock, period 8 time units. */
`default_nettype none

module tb_clock_gen (
	output logic clk_sys
);
	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;
endmodule

`default_nettype wire

// File: verilog/backup_ram_sync.sv
/* Backup RAM to save image copy in 512-byte sectors.
   sd_rd/sd_wr are held until sd_ack rises; the next sector waits for ack low. */
`default_nettype none

module backup_ram_sync (
	load_bus_if.sink            bus,
	input  cart_pkg::mem_mask_t ram_mask,
	input  wire                 img_mounted,
	input  wire                 img_readonly,
	input  wire [63:0]          img_size,
	input  wire                 bk_load_req,
	input  wire                 bk_save_req,
	input  wire                 sd_ack,
	output cart_pkg::lba_t      sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic                bk_busy,
	output logic                bk_loading
);
	import cart_pkg::*;

	bk_state_t state;
	logic      bk_ena;
	logic      old_download;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_start;
	logic      save_start;
	logic      auto_start;
	lba_t      last_lba;

	assign load_start = bk_load_req & ~old_load & bk_ena;
	assign save_start = bk_save_req & ~old_save & bk_ena;
	// Save image is read back once the cartridge is in
	assign auto_start = old_download & ~bus.cart_download & (|img_size) & bk_ena;
	assign last_lba   = lba_t'(ram_mask >> SECTOR_BITS);

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			state        <= BK_IDLE;
			bk_ena       <= 1'b0;
			bk_loading   <= 1'b0;
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_ack      <= 1'b0;
			sd_lba       <= '0;
			sd_rd        <= 1'b0;
			sd_wr        <= 1'b0;
		end else begin
			old_download <= bus.cart_download;
			old_load     <= bk_load_req;
			old_save     <= bk_save_req;
			old_ack      <= sd_ack;

			if (!old_download && bus.cart_download)
				bk_ena <= 1'b0;
			if (bus.cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (state == BK_IDLE) begin
				if (load_start || save_start) begin
					state      <= BK_XFER;
					bk_loading <= load_start;
					sd_lba     <= '0;
					sd_rd      <= load_start;
					sd_wr      <= ~load_start;
				end
				if (auto_start) begin
					state      <= BK_XFER;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					state      <= BK_IDLE;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + lba_t'(1);
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	assign bk_busy = (state == BK_XFER);

	a_rd_wr_exclusive: assert property (
		@(posedge bus.clk_sys) disable iff (bus.RESET) !(sd_rd && sd_wr)
	);

endmodule

`default_nettype wire

// File: verilog/cart_loader_top.sv
/* Cartridge loader top. The RAMs and the sector buffer live outside;
   only the work-RAM fill port and the sector handshake are driven here. */
`default_nettype none

module cart_loader_top (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire                     ioctl_download,
	input  wire [7:0]               ioctl_index,
	input  cart_pkg::load_addr_t    ioctl_addr,
	input  cart_pkg::load_word_t    ioctl_dout,
	input  wire                     ioctl_wr,
	input  cart_pkg::header_sel_t   header_sel,
	input  wire [1:0]               region_sel,
	input  cart_pkg::wram_pattern_t wram_pattern,
	input  wire                     img_mounted,
	input  wire                     img_readonly,
	input  wire [63:0]              img_size,
	input  wire                     bk_load_req,
	input  wire                     bk_save_req,
	input  wire                     sd_ack,
	output cart_pkg::rom_type_t     rom_type,
	output cart_pkg::mem_mask_t     rom_mask,
	output cart_pkg::mem_mask_t     ram_mask,
	output logic                    pal,
	output cart_pkg::cheat_code_t   gg_code,
	output logic                    gg_code_valid,
	output cart_pkg::fill_addr_t    fill_addr,
	output cart_pkg::fill_data_t    fill_data,
	output logic                    fill_wr,
	output cart_pkg::lba_t          sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output logic                    bk_busy,
	output logic                    bk_loading,
	output logic                    core_reset
);
	import cart_pkg::*;

	logic code_index;
	logic clearing;

	load_bus_if bus ();

	// ======================================================================
	// Download split by file index
	// ======================================================================
	assign code_index = (ioctl_index == CODE_FILE_INDEX);

	assign bus.clk_sys       = clk_sys;
	assign bus.RESET         = RESET;
	assign bus.cart_download = ioctl_download & ~code_index;
	assign bus.code_download = ioctl_download & code_index;
	assign bus.wr            = ioctl_wr;
	assign bus.addr          = ioctl_addr;
	assign bus.dout          = ioctl_dout;

	// Core held in reset while the cartridge or its RAM is being set up
	assign core_reset = RESET | bus.cart_download | bk_loading | clearing;

	rom_header_detect u_hdr (
		.bus        (bus.sink),
		.header_sel (header_sel),
		.region_sel (region_sel),
		.rom_type   (rom_type),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.pal        (pal)
	);

	cheat_code_assembler u_cheat (
		.bus           (bus.sink),
		.gg_code       (gg_code),
		.gg_code_valid (gg_code_valid)
	);

	ram_clear_sequencer u_clear (
		.bus          (bus.sink),
		.wram_pattern (wram_pattern),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data),
		.fill_wr      (fill_wr),
		.clearing     (clearing)
	);

	backup_ram_sync u_bk (
		.bus          (bus.sink),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

`default_nettype wire

// File: verilog/cart_pkg.sv
/* Widths, encodings and constants shared by the cartridge loader blocks.
   Header addresses assume a 512-byte copier header in front of the image. */
`default_nettype none

package cart_pkg;

	localparam int FILL_ADDR_BITS = 17;
	localparam int SECTOR_BITS    = 9;

	typedef logic [24:0]               load_addr_t;
	typedef logic [15:0]               load_word_t;
	typedef logic [23:0]               mem_mask_t;
	typedef logic [3:0]                size_code_t;
	typedef logic [7:0]                rom_type_t;
	typedef logic [FILL_ADDR_BITS-1:0] fill_addr_t;
	typedef logic [7:0]                fill_data_t;
	typedef logic [31:0]               lba_t;
	// {strobe, flags, address, compare, replace}
	typedef logic [128:0]              cheat_code_t;

	typedef enum logic [2:0] {
		HDR_AUTO,
		HDR_NONE,
		HDR_LOROM,
		HDR_HIROM,
		HDR_EXHIROM
	} header_sel_t;

	typedef enum logic [1:0] {
		PAT_9966,
		PAT_00FF,
		PAT_55,
		PAT_FF
	} wram_pattern_t;

	typedef enum logic {BK_IDLE, BK_XFER} bk_state_t;

	localparam logic [7:0] CODE_FILE_INDEX  = 8'hFF;
	localparam int         HEADER_SKIP      = 512;
	localparam load_addr_t LOROM_HDR_BASE   = 25'h0007FC0;
	localparam load_addr_t HIROM_HDR_BASE   = 25'h000FFC0;
	localparam load_addr_t EXHIROM_HDR_BASE = 25'h040FFC0;
	localparam int         DEFAULT_ROM_SIZE = 12;
	localparam int         MASK_UNIT        = 1024;

endpackage

`default_nettype wire

// File: verilog/cheat_code_assembler.sv
/* Packs eight code-file words into one cheat record.
   Odd offsets are ignored; the record is strobed by the offset 14 word. */
`default_nettype none

module cheat_code_assembler (
	load_bus_if.sink              bus,
	output cart_pkg::cheat_code_t gg_code,
	output logic                  gg_code_valid
);
	import cart_pkg::*;

	logic [127:0] code_body;
	logic         code_wr;

	assign code_wr = bus.code_download & bus.wr;

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET)
			gg_code_valid <= 1'b0;
		else
			gg_code_valid <= code_wr && bus.addr[3:0] == 4'd14;
	end

	// Low word first for each field
	always_ff @(posedge bus.clk_sys) begin
		if (code_wr) begin
			case (bus.addr[3:0])
				4'd0:  code_body[111:96]  <= bus.dout;
				4'd2:  code_body[127:112] <= bus.dout;
				4'd4:  code_body[79:64]   <= bus.dout;
				4'd6:  code_body[95:80]   <= bus.dout;
				4'd8:  code_body[47:32]   <= bus.dout;
				4'd10: code_body[63:48]   <= bus.dout;
				4'd12: code_body[15:0]    <= bus.dout;
				4'd14: code_body[31:16]   <= bus.dout;
				default: ;
			endcase
		end
	end

	assign gg_code = {gg_code_valid, code_body};

endmodule

`default_nettype wire

// File: verilog/load_bus_if.sv
/* Decoded host load stream. One word per wr strobe. */
`default_nettype none

interface load_bus_if;
	import cart_pkg::*;

	logic       clk_sys;
	logic       RESET;
	logic       cart_download;
	logic       code_download;
	logic       wr;
	load_addr_t addr;
	load_word_t dout;

	// Driven by the top level only
	modport src (
		output clk_sys, RESET, cart_download, code_download, wr, addr, dout
	);

	modport sink (
		input clk_sys, RESET, cart_download, code_download, wr, addr, dout
	);

endinterface

`default_nettype wire

// File: verilog/ram_clear_sequencer.sv
/* Work-RAM power-on fill. One sweep of 2^17 byte writes per cartridge load,
   started by the rising edge of the download. */
`default_nettype none

module ram_clear_sequencer (
	load_bus_if.sink                bus,
	input  cart_pkg::wram_pattern_t wram_pattern,
	output cart_pkg::fill_addr_t    fill_addr,
	output cart_pkg::fill_data_t    fill_data,
	output logic                    fill_wr,
	output logic                    clearing
);
	import cart_pkg::*;

	logic old_download;

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			old_download <= 1'b0;
			clearing     <= 1'b0;
			fill_addr    <= '0;
		end else begin
			old_download <= bus.cart_download;
			if (!old_download && bus.cart_download)
				clearing <= 1'b1;
			// Last address written, stop after this cycle
			if (&fill_addr)
				clearing <= 1'b0;
			fill_addr <= clearing ? fill_addr + fill_addr_t'(1) : '0;
		end
	end

	assign fill_wr = clearing;

	// ======================================================================
	// Fill patterns
	// ======================================================================
	always_comb begin
		case (wram_pattern)
			PAT_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			PAT_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			PAT_55:   fill_data = 8'h55;
			default:  fill_data = 8'hFF;
		endcase
	end

	a_addr_idle_zero: assert property (
		@(posedge bus.clk_sys) disable iff (bus.RESET) !clearing |-> fill_addr == '0
	);

endmodule

`default_nettype wire

// File: verilog/rom_header_detect.sv
/* ROM type, size masks and video region from the image header.
   Fixed header modes read the internal header; auto mode uses word 0 only. */
`default_nettype none

module rom_header_detect (
	load_bus_if.sink              bus,
	input  cart_pkg::header_sel_t header_sel,
	input  wire [1:0]             region_sel,
	output cart_pkg::rom_type_t   rom_type,
	output cart_pkg::mem_mask_t   rom_mask,
	output cart_pkg::mem_mask_t   ram_mask,
	output logic                  pal
);
	import cart_pkg::*;

	size_code_t rom_size;
	size_code_t ram_size;
	logic       rom_region;
	logic       hdr_wr;
	logic       hdr_fixed;
	load_addr_t hdr_base;
	load_addr_t rom_size_addr;
	load_addr_t ram_size_addr;

	assign hdr_wr = bus.cart_download & bus.wr;

	// Internal header location for the forced modes
	always_comb begin
		hdr_fixed = 1'b1;
		case (header_sel)
			HDR_LOROM:   hdr_base = LOROM_HDR_BASE;
			HDR_HIROM:   hdr_base = HIROM_HDR_BASE;
			HDR_EXHIROM: hdr_base = EXHIROM_HDR_BASE;
			default: begin
				hdr_base  = '0;
				hdr_fixed = 1'b0;
			end
		endcase
	end

	assign rom_size_addr = hdr_base + load_addr_t'('h16 + HEADER_SKIP);
	assign ram_size_addr = hdr_base + load_addr_t'('h18 + HEADER_SKIP);

	always_ff @(posedge bus.clk_sys) begin
		if (bus.RESET) begin
			rom_size   <= size_code_t'(DEFAULT_ROM_SIZE);
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (hdr_wr) begin
				if (bus.addr == '0) begin
					rom_size <= size_code_t'(DEFAULT_ROM_SIZE);
					ram_size <= '0;
					// Loader-supplied sizes: RAM in high nibble, ROM in low
					if (header_sel == HDR_AUTO && bus.dout[7:0] != 8'h00) begin
						ram_size <= bus.dout[7:4];
						rom_size <= bus.dout[3:0];
					end
					case (header_sel)
						HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
						HDR_HIROM:           rom_type <= 8'd1;
						HDR_EXHIROM:         rom_type <= 8'd2;
						default:             rom_type <= bus.dout[15:8];
					endcase
				end
				if (bus.addr == load_addr_t'(2))
					rom_region <= bus.dout[8];
				if (hdr_fixed && bus.addr == rom_size_addr)
					rom_size <= bus.dout[11:8];
				if (hdr_fixed && bus.addr == ram_size_addr)
					ram_size <= bus.dout[3:0];
			end
			// Region frozen while a cartridge streams in
			if (!bus.cart_download)
				pal <= (region_sel == 2'b00) ? rom_region : region_sel[1];
		end
	end

	assign rom_mask = (mem_mask_t'(MASK_UNIT) << rom_size) - mem_mask_t'(1);
	assign ram_mask = (ram_size != '0) ?
		(mem_mask_t'(MASK_UNIT) << ram_size) - mem_mask_t'(1) : '0;

	// Sizes up to 15 wrap to all ones, never to zero
	a_rom_mask_nonzero: assert property (
		@(posedge bus.clk_sys) disable iff (bus.RESET) rom_mask != '0
	);

endmodule

`default_nettype wire
